//--- alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module alu
    import cpu_pkg::*;
(
    input  logic [`CPU_XLEN-1:0] op_a,
    input  logic [`CPU_XLEN-1:0] op_b,
    input  alu_op_e              op,
    output logic [`CPU_XLEN-1:0] result
);

    // shift amount, low five bits of operand two
    logic [4:0] shamt;

    assign shamt = op_b[4:0];

    always_comb
    begin
        case (op)
            ADD:
                result = op_a + op_b;
            SUB:
                result = op_a - op_b;
            AND:
                result = op_a & op_b;
            OR:
                result = op_a | op_b;
            XOR:
                result = op_a ^ op_b;
            // logical shifts fill with zero
            SRL:
                result = op_a >> shamt;
            SLL:
                result = op_a << shamt;
            // arithmetic right keeps the sign
            SRA:
                result = $signed(op_a) >>> shamt;
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- cpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_ctrl
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    input  logic                 halt_button,
    rf_if.ctrl                   rf,
    mem_if.ctrl                  mem,
    output logic [`CPU_XLEN-1:0] alu_a,
    output logic [`CPU_XLEN-1:0] alu_b,
    output alu_op_e              alu_op,
    input  logic [`CPU_XLEN-1:0] alu_result,
    output logic                 done
);

    localparam int IMM16_W = `CPU_IMM16_MSB - `CPU_IMM16_LSB + 1;
    localparam int IMM23_W = `CPU_IMM23_MSB - `CPU_IMM23_LSB + 1;

    cpu_state_e              state;
    logic [`CPU_XLEN-1:0]    pc;
    logic [`CPU_XLEN-1:0]    ir;
    // payload registers, loaded by state
    logic [`CPU_XLEN-1:0]    npc;
    logic [`CPU_XLEN-1:0]    a_reg;
    logic [`CPU_XLEN-1:0]    b_reg;
    logic [`CPU_XLEN-1:0]    imm;
    logic [`CPU_XLEN-1:0]    alu_out;
    logic [`CPU_XLEN-1:0]    lmd;
    // decode of the held instruction
    opcode_e                 opc;
    logic [`CPU_FUNCT_MSB:0] funct;
    logic [`CPU_XLEN-1:0]    imm_ext;
    logic                    is_store;
    logic                    is_halt;
    logic                    wb_en;
    logic                    cond_ok;

    assign opc      = opcode_e'(ir[`CPU_OPC_MSB:`CPU_OPC_LSB]);
    assign funct    = ir[`CPU_FUNCT_MSB:0];
    assign is_store = funct[0];
    assign is_halt  = (opc == OPC_PCTRL) && ir[`CPU_HALT_BIT];
    assign wb_en    = (opc == OPC_ALU) || (opc == OPC_MOVE) || ((opc == OPC_LDST) && !is_store);

    // imm16 for alu and ld/st, imm23 for branches, zero makes move an A pass
    always_comb
    begin
        case (opc)
            OPC_ALU, OPC_LDST:
                imm_ext = {{(`CPU_XLEN - IMM16_W){ir[`CPU_IMM16_MSB]}},
                           ir[`CPU_IMM16_MSB:`CPU_IMM16_LSB]};
            OPC_BRANCH:
                imm_ext = {{(`CPU_XLEN - IMM23_W){ir[`CPU_IMM23_MSB]}},
                           ir[`CPU_IMM23_MSB:`CPU_IMM23_LSB]};
            default:
                imm_ext = '0;
        endcase
    end

    // operand select: branch target is pc + imm, immediate form uses imm
    assign alu_a  = (opc == OPC_BRANCH) ? pc : a_reg;
    assign alu_b  = ((opc != OPC_ALU) || funct[`CPU_IMMSEL_BIT]) ? imm : b_reg;
    assign alu_op = (opc == OPC_ALU) ? alu_op_e'(funct[2:0]) : ADD;

    // branch condition, tested on rs
    always_comb
    begin
        case (branch_cond_e'(ir[`CPU_COND_MSB:0]))
            ALWAYS:   cond_ok = 1'b1;
            ZERO:     cond_ok = (a_reg == '0);
            NONZERO:  cond_ok = (a_reg != '0);
            NEGATIVE: cond_ok = a_reg[`CPU_XLEN-1];
            default:  cond_ok = 1'b0;
        endcase
    end

    // register file hookup, rt target for immediate alu ops
    assign rf.raddr1 = ir[`CPU_RS_MSB -: `CPU_REG_AW];
    assign rf.raddr2 = ir[`CPU_RT_MSB -: `CPU_REG_AW];
    assign rf.we     = (state == WRITEBACK) && wb_en;
    assign rf.waddr  = ((opc == OPC_ALU) && !funct[`CPU_IMMSEL_BIT]) ?
                       ir[`CPU_RD_MSB -: `CPU_REG_AW] : ir[`CPU_RT_MSB -: `CPU_REG_AW];
    assign rf.wdata  = (opc == OPC_LDST) ? lmd : alu_out;

    // word addressed memories, pc steps by one
    assign mem.iaddr  = pc[`CPU_MEM_AW-1:0];
    assign mem.daddr  = alu_out[`CPU_MEM_AW-1:0];
    assign mem.dwdata = b_reg;
    assign mem.dwe    = (state == MEMORY) && (opc == OPC_LDST) && is_store;

    assign done = (state == DONE);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            pc    <= '0;
            ir    <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (run)
                        state <= FETCH;
                FETCH:
                begin
                    ir    <= mem.instr;
                    state <= DECODE;
                end
                // halt parks here for as long as the button is held
                DECODE:
                    if (opc == OPC_TERM)
                        state <= DONE;
                    else if (!(is_halt && halt_button))
                        state <= EXECUTE;
                EXECUTE:
                    state <= MEMORY;
                // pc update for every class, including the no-op stack codes
                MEMORY:
                begin
                    pc    <= ((opc == OPC_BRANCH) && cond_ok) ? alu_out : npc;
                    state <= WRITEBACK;
                end
                WRITEBACK:
                    state <= FETCH;
                DONE:
                    state <= DONE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        case (state)
            FETCH:
                npc <= pc + 1'b1;
            DECODE:
            begin
                a_reg <= rf.rdata1;
                b_reg <= rf.rdata2;
                imm   <= imm_ext;
            end
            EXECUTE:
                alu_out <= alu_result;
            MEMORY:
                if ((opc == OPC_LDST) && !is_store)
                    lmd <= mem.drdata;
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and register file sizing
`define CPU_XLEN        32
`define CPU_NREGS       16
`define CPU_REG_AW      4

// instruction and data memories share one depth
`define CPU_MEM_DEPTH   256
`define CPU_MEM_AW      8

// apb byte address, word index starts at bit 2
`define CPU_APB_AW      12
`define CPU_APB_IDX_LSB 2
// set for data memory, clear for instruction memory
`define CPU_APB_SEL_BIT 10

// instruction fields
`define CPU_OPC_MSB     31
`define CPU_OPC_LSB     29
`define CPU_RS_MSB      28
`define CPU_RT_MSB      24
`define CPU_RD_MSB      20
`define CPU_IMM16_MSB   20
`define CPU_IMM16_LSB   5
`define CPU_IMM23_MSB   24
`define CPU_IMM23_LSB   2
`define CPU_FUNCT_MSB   4
`define CPU_IMMSEL_BIT  4
`define CPU_HALT_BIT    28
// branch condition sits in the two lsbs
`define CPU_COND_MSB    1

`endif

//--- cpu_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    mem_if.mem                     mem,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`CPU_APB_AW-1:0] paddr,
    input  logic [`CPU_XLEN-1:0]   pwdata,
    output logic [`CPU_XLEN-1:0]   prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic [`CPU_XLEN-1:0]   imem [`CPU_MEM_DEPTH];
    logic [`CPU_XLEN-1:0]   dmem [`CPU_MEM_DEPTH];
    logic                   apb_access;
    logic                   apb_ok;
    logic                   apb_dsel;
    logic                   apb_wr;
    logic [`CPU_MEM_AW-1:0] apb_idx;

    // access phase of a transfer
    assign apb_access = psel & penable;
    // host side only allowed while the cpu is stopped
    assign apb_ok     = apb_access & ~run;
    assign apb_dsel   = paddr[`CPU_APB_SEL_BIT];
    assign apb_idx    = paddr[`CPU_APB_IDX_LSB +: `CPU_MEM_AW];
    // no memory updates while in reset
    assign apb_wr     = apb_ok & pwrite & ~rst;

    // zero wait states
    assign pready  = apb_access;
    assign pslverr = apb_access & run;

    // read data only on an accepted access, zero otherwise
    always_comb
    begin
        if (!apb_ok)
            prdata = '0;
        else if (apb_dsel)
            prdata = dmem[apb_idx];
        else
            prdata = imem[apb_idx];
    end

    // cpu side, combinational reads
    assign mem.instr  = imem[mem.iaddr];
    assign mem.drdata = dmem[mem.daddr];

    // imem is written only through apb
    always_ff @(posedge clk)
    begin
        if (apb_wr && !apb_dsel)
            imem[apb_idx] <= pwdata;
    end

    // cpu store wins, though apb and run never overlap in practice
    always_ff @(posedge clk)
    begin
        if (mem.dwe)
            dmem[mem.daddr] <= mem.dwdata;
        else if (apb_wr && apb_dsel)
            dmem[apb_idx] <= pwdata;
    end

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // controller states, one instruction walks fetch to writeback
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        FETCH     = 3'd1,
        DECODE    = 3'd2,
        EXECUTE   = 3'd3,
        MEMORY    = 3'd4,
        WRITEBACK = 3'd5,
        DONE      = 3'd6
    } cpu_state_e;

    // major opcode in ir[31:29]
    // stack classes are kept only as no-op encodings
    typedef enum logic [2:0] {
        OPC_ALU    = 3'b000,
        OPC_LDST   = 3'b001,
        OPC_BRANCH = 3'b010,
        OPC_STACK  = 3'b011,
        OPC_MOVE   = 3'b100,
        OPC_PCTRL  = 3'b101,
        OPC_STALU  = 3'b110,
        OPC_TERM   = 3'b111
    } opcode_e;

    // alu function, taken from funct[2:0]
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SRL = 3'd5,
        SLL = 3'd6,
        SRA = 3'd7
    } alu_op_e;

    // branch test applied to the rs value
    typedef enum logic [1:0] {
        ALWAYS   = 2'd0,
        ZERO     = 2'd1,
        NONZERO  = 2'd2,
        NEGATIVE = 2'd3
    } branch_cond_e;

endpackage

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   halt_button,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`CPU_APB_AW-1:0] paddr,
    input  logic [`CPU_XLEN-1:0]   pwdata,
    output logic [`CPU_XLEN-1:0]   prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   done
);

    // alu operands and result between controller and alu
    logic [`CPU_XLEN-1:0] alu_a;
    logic [`CPU_XLEN-1:0] alu_b;
    logic [`CPU_XLEN-1:0] alu_result;
    alu_op_e              alu_op;

    rf_if  rf_bus ();
    mem_if mem_bus ();

    reg_file u_reg_file (
        .clk (clk),
        .rst (rst),
        .rf  (rf_bus.rf)
    );

    alu u_alu (
        .op_a   (alu_a),
        .op_b   (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    // memories also carry the apb slave used for load and readback
    cpu_mem u_cpu_mem (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .mem     (mem_bus.mem),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    cpu_ctrl u_cpu_ctrl (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .halt_button (halt_button),
        .rf          (rf_bus.ctrl),
        .mem         (mem_bus.ctrl),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_op      (alu_op),
        .alu_result  (alu_result),
        .done        (done)
    );

endmodule

`default_nettype wire

//--- list.f
+incdir+.
cpu_pkg.sv
rf_if.sv
mem_if.sv
reg_file.sv
alu.sv
cpu_mem.sv
cpu_ctrl.sv
cpu_top.sv
tb_cpu.sv

//--- mem_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

interface mem_if;

    // instruction side, read only from the cpu
    logic [`CPU_MEM_AW-1:0] iaddr;
    logic [`CPU_XLEN-1:0]   instr;

    // data side, one read and one write port on a shared address
    logic [`CPU_MEM_AW-1:0] daddr;
    logic [`CPU_XLEN-1:0]   dwdata;
    logic                   dwe;
    logic [`CPU_XLEN-1:0]   drdata;

    modport ctrl (output iaddr, daddr, dwdata, dwe, input instr, drdata);
    modport mem (input iaddr, daddr, dwdata, dwe, output instr, drdata);

endinterface

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module reg_file (
    input  logic clk,
    input  logic rst,
    rf_if.rf     rf
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // r0 is a normal register here, no hardwired zero
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rf.we)
        begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // async reads, no write bypass
    assign rf.rdata1 = regs[rf.raddr1];
    assign rf.rdata2 = regs[rf.raddr2];

endmodule

`default_nettype wire

//--- rf_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

interface rf_if;

    // two read ports, driven by decode fields
    logic [`CPU_REG_AW-1:0] raddr1;
    logic [`CPU_REG_AW-1:0] raddr2;
    logic [`CPU_XLEN-1:0]   rdata1;
    logic [`CPU_XLEN-1:0]   rdata2;

    // single write port, used in writeback
    logic                   we;
    logic [`CPU_REG_AW-1:0] waddr;
    logic [`CPU_XLEN-1:0]   wdata;

    modport ctrl (output raddr1, raddr2, we, waddr, wdata, input rdata1, rdata2);
    modport rf (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);

endinterface

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam int RUN_LIMIT   = 5000;
    localparam int APB_LIMIT   = 16;
    localparam int MODEL_LIMIT = 5000;
    // bit 10 of the byte address picks data memory
    localparam logic [`CPU_APB_AW-1:0] DMEM_SEL = 12'h400;

    logic                   clk;
    logic                   rst;
    logic                   run;
    logic                   halt_button;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`CPU_APB_AW-1:0] paddr;
    logic [`CPU_XLEN-1:0]   pwdata;
    logic [`CPU_XLEN-1:0]   prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   done;

    // reference machine state
    logic [`CPU_XLEN-1:0] m_imem [`CPU_MEM_DEPTH];
    logic [`CPU_XLEN-1:0] m_dmem [`CPU_MEM_DEPTH];
    logic [`CPU_XLEN-1:0] m_regs [`CPU_NREGS];
    logic [`CPU_XLEN-1:0] snap [`CPU_MEM_DEPTH];
    logic [`CPU_XLEN-1:0] prog [$];

    cpu_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .halt_button (halt_button),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .done        (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("** Error: %s expected 0x%08h got 0x%08h", name, exp, got);
        abort_run();
    endtask

    task automatic timed_out(input string what);
        $display("timeout: %s", what);
        abort_run();
    endtask

    // done drops again only with reset
    done_holds: assert property (@(posedge clk) disable iff (rst) done |=> done)
    else
    begin
        $display("** Error: done expected 0x1 got 0x0");
        abort_run();
    end

    // error response only while the cpu runs
    err_needs_run: assert property (@(posedge clk) disable iff (rst) pslverr |-> run)
    else
    begin
        $display("** Error: pslverr expected 0x0 got 0x1");
        abort_run();
    end

    // zero wait states on every access cycle
    no_wait: assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> pready)
    else
    begin
        $display("** Error: pready expected 0x1 got 0x0");
        abort_run();
    end

    // instruction encoders
    function automatic logic [31:0] alu_reg(alu_op_e op, logic [3:0] rd, logic [3:0] rs,
                                            logic [3:0] rt);
        return {OPC_ALU, rs, rt, rd, 12'd0, 2'b00, op};
    endfunction

    function automatic logic [31:0] alu_imm(alu_op_e op, logic [3:0] rt, logic [3:0] rs,
                                            logic [15:0] imm);
        return {OPC_ALU, rs, rt, imm, 2'b10, op};
    endfunction

    // st is set for a store and clear for a load
    function automatic logic [31:0] mem_op(logic st, logic [3:0] rt, logic [3:0] rs,
                                           logic [15:0] imm);
        return {OPC_LDST, rs, rt, imm, 4'b0000, st};
    endfunction

    function automatic logic [31:0] branch_to(branch_cond_e cond, logic [3:0] rs,
                                              logic [22:0] off);
        return {OPC_BRANCH, rs, off, cond};
    endfunction

    function automatic logic [31:0] move_reg(logic [3:0] rt, logic [3:0] rs);
        return {OPC_MOVE, rs, rt, 21'd0};
    endfunction

    function automatic logic [31:0] pctrl_op(logic halt);
        return {OPC_PCTRL, halt, 28'd0};
    endfunction

    function automatic logic [31:0] stack_nop(opcode_e opc);
        return {opc, 29'($urandom())};
    endfunction

    // alu rules where shifts take five bits of operand two
    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SRL:     return a >> b[4:0];
            SLL:     return a << b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    // one setup and one access cycle with sampling at the falling edge
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready)
        begin
            if (n >= APB_LIMIT)
                timed_out("pready stayed low in an apb access cycle");
            @(negedge clk);
            n++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_xfer(1'b1, addr, data, unused, err);
        assert (!err)
        else
            mismatch("pslverr", 32'd0, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        assert (!err)
        else
            mismatch("pslverr", 32'd0, err);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst         <= 1'b1;
        run         <= 1'b0;
        halt_button <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        run <= 1'b1;
    endtask

    task automatic stop_run();
        @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!done)
        begin
            if (n >= limit)
                timed_out("done never rose");
            @(negedge clk);
            n++;
        end
    endtask

    // program into imem and fresh random words into all of dmem
    task automatic load_program();
        for (int i = 0; i < prog.size(); i++)
        begin
            apb_write(12'(i << 2), prog[i]);
            m_imem[i] = prog[i];
        end
        for (int i = 0; i < `CPU_MEM_DEPTH; i++)
        begin
            m_dmem[i] = $urandom();
            apb_write(DMEM_SEL | 12'(i << 2), m_dmem[i]);
        end
    endtask

    // isa model where registers start at zero after reset
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] ins;
        logic [31:0] rs_v;
        logic [31:0] rt_v;
        logic [31:0] i16;
        logic [31:0] i23;
        logic [31:0] ea;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic        taken;
        int          steps;
        for (int i = 0; i < `CPU_NREGS; i++)
            m_regs[i] = '0;
        pc = '0;
        steps = 0;
        ins = m_imem[pc[7:0]];
        while (ins[31:29] != OPC_TERM)
        begin
            if (steps >= MODEL_LIMIT)
                timed_out("reference model never reached terminate");
            rs   = ins[28:25];
            rt   = ins[24:21];
            rs_v = m_regs[rs];
            rt_v = m_regs[rt];
            i16  = {{16{ins[20]}}, ins[20:5]};
            i23  = {{9{ins[24]}}, ins[24:2]};
            ea   = rs_v + i16;
            next = pc + 1;
            case (opcode_e'(ins[31:29]))
                OPC_ALU:
                    if (ins[4])
                        m_regs[rt] = alu_ref(alu_op_e'(ins[2:0]), rs_v, i16);
                    else
                        m_regs[ins[20:17]] = alu_ref(alu_op_e'(ins[2:0]), rs_v, rt_v);
                OPC_LDST:
                    if (ins[0])
                        m_dmem[ea[7:0]] = rt_v;
                    else
                        m_regs[rt] = m_dmem[ea[7:0]];
                OPC_BRANCH:
                begin
                    case (branch_cond_e'(ins[1:0]))
                        ALWAYS:  taken = 1'b1;
                        ZERO:    taken = (rs_v == 0);
                        NONZERO: taken = (rs_v != 0);
                        default: taken = rs_v[31];
                    endcase
                    if (taken)
                        next = pc + i23;
                end
                OPC_MOVE:
                    m_regs[rt] = rs_v;
                // stack codes and pctrl leave state alone
                default:
                begin
                end
            endcase
            pc = next;
            steps++;
            ins = m_imem[pc[7:0]];
        end
    endtask

    task automatic check_dmem();
        logic [31:0] got;
        for (int i = 0; i < `CPU_MEM_DEPTH; i++)
        begin
            apb_read(DMEM_SEL | 12'(i << 2), got);
            assert (got == m_dmem[i])
            else
                mismatch($sformatf("dmem[%0d]", i), m_dmem[i], got);
            snap[i] = got;
        end
    endtask

    task automatic run_and_compare();
        load_program();
        run_model();
        start_run();
        wait_done(RUN_LIMIT);
        stop_run();
        check_dmem();
    endtask

    // every op in register and immediate form with results stored to dmem 0..15
    task automatic build_alu_prog();
        prog = {};
        prog.push_back(alu_imm(ADD, 1, 0, 16'($urandom()) | 16'h8000));
        prog.push_back(alu_imm(SLL, 1, 1, 16'd13));
        prog.push_back(alu_imm(XOR, 1, 1, 16'($urandom())));
        prog.push_back(alu_imm(ADD, 2, 0, 16'($urandom())));
        for (int op = 0; op < 8; op++)
        begin
            prog.push_back(alu_reg(alu_op_e'(op), 4, 1, 2));
            prog.push_back(mem_op(1'b1, 4, 0, 16'(op)));
            prog.push_back(alu_imm(alu_op_e'(op), 5, 1, 16'($urandom())));
            prog.push_back(mem_op(1'b1, 5, 0, 16'(8 + op)));
        end
        prog.push_back({OPC_TERM, 29'd0});
    endtask

    // store off a base register then load back, move and store again
    task automatic build_ldst_prog();
        logic [15:0] offs [4];
        prog = {};
        prog.push_back(alu_imm(ADD, 10, 0, 16'($urandom_range(0, 255))));
        for (int i = 0; i < 4; i++)
        begin
            offs[i] = 16'($urandom());
            prog.push_back(alu_imm(ADD, 4'(1 + i), 0, 16'($urandom())));
            prog.push_back(mem_op(1'b1, 4'(1 + i), 10, offs[i]));
        end
        for (int i = 0; i < 4; i++)
        begin
            prog.push_back(mem_op(1'b0, 4'(5 + i), 10, offs[i]));
            prog.push_back(move_reg(4'(11 + i), 4'(5 + i)));
            prog.push_back(mem_op(1'b1, 4'(11 + i), 0, 16'($urandom())));
        end
        prog.push_back({OPC_TERM, 29'd0});
    endtask

    // taken case skips the marker store that follows it
    task automatic branch_case(input branch_cond_e cond, input logic [3:0] rs, input int addr);
        prog.push_back(branch_to(cond, rs, 23'd2));
        prog.push_back(mem_op(1'b1, 6, 0, 16'(addr)));
    endtask

    task automatic build_branch_prog();
        prog = {};
        prog.push_back(alu_imm(ADD, 1, 0, 16'($urandom_range(3, 9))));
        prog.push_back(alu_imm(ADD, 3, 0, 16'd1));
        prog.push_back(alu_imm(ADD, 7, 0, 16'($urandom()) | 16'h8000));
        prog.push_back(alu_imm(ADD, 8, 0, (16'($urandom()) & 16'h7fff) | 16'h0001));
        prog.push_back(alu_imm(ADD, 6, 0, 16'($urandom()) | 16'h0001));
        // countdown loop with stack codes inside
        prog.push_back(alu_reg(ADD, 2, 2, 3));
        prog.push_back(stack_nop(OPC_STACK));
        prog.push_back(alu_imm(SUB, 1, 1, 16'd1));
        prog.push_back(stack_nop(OPC_STALU));
        prog.push_back(branch_to(NONZERO, 1, -23'sd4));
        prog.push_back(mem_op(1'b1, 2, 0, 16'd40));
        prog.push_back(pctrl_op(1'b0));
        branch_case(ZERO, 1, 41);
        branch_case(ZERO, 8, 42);
        branch_case(NEGATIVE, 7, 43);
        branch_case(NEGATIVE, 8, 44);
        branch_case(NONZERO, 8, 45);
        branch_case(NONZERO, 1, 46);
        branch_case(ALWAYS, 8, 47);
        prog.push_back({OPC_TERM, 29'd0});
    endtask

    task automatic build_halt_prog();
        prog = {};
        prog.push_back(alu_imm(ADD, 1, 0, 16'($urandom())));
        prog.push_back(alu_imm(ADD, 2, 0, 16'($urandom())));
        prog.push_back(pctrl_op(1'b0));
        prog.push_back(pctrl_op(1'b1));
        prog.push_back(alu_reg(ADD, 3, 1, 2));
        prog.push_back(mem_op(1'b1, 3, 0, 16'd7));
        prog.push_back(mem_op(1'b1, 1, 0, 16'd9));
        prog.push_back({OPC_TERM, 29'd0});
    endtask

    initial
    begin
        logic [31:0]   imem_vals [16];
        logic [31:0]   dmem_vals [16];
        logic [31:0]   got;
        logic [31:0]   old;
        logic          err;
        logic [11:0]   addr;
        logic [7:0]    base;
        int unsigned   hold;
        void'($urandom(32'h3512_1053));
        rst         = 1'b1;
        run         = 1'b0;
        halt_button = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        apply_reset();

        // apb round trip in both memories at the same word indices
        base = 8'($urandom());
        for (int k = 0; k < 16; k++)
        begin
            addr         = {2'b00, 8'(base + k), 2'b00};
            imem_vals[k] = $urandom();
            dmem_vals[k] = $urandom();
            apb_write(addr, imem_vals[k]);
            apb_write(DMEM_SEL | addr, dmem_vals[k]);
        end
        for (int k = 0; k < 16; k++)
        begin
            addr = {2'b00, 8'(base + k), 2'b00};
            apb_read(addr, got);
            assert (got == imem_vals[k])
            else
                mismatch($sformatf("prdata at 0x%03h", addr), imem_vals[k], got);
            apb_read(DMEM_SEL | addr, got);
            assert (got == dmem_vals[k])
            else
                mismatch($sformatf("prdata at 0x%03h", DMEM_SEL | addr), dmem_vals[k], got);
        end

        // rejected access while the cpu is parked in done
        apb_write(12'h000, {OPC_TERM, 29'd0});
        addr = DMEM_SEL | {2'b00, 8'(base + $urandom_range(0, 15)), 2'b00};
        apb_read(addr, old);
        start_run();
        wait_done(RUN_LIMIT);
        apb_xfer(1'b1, addr, ~old, got, err);
        assert (err)
        else
            mismatch("pslverr", 32'd1, err);
        apb_xfer(1'b0, addr, '0, got, err);
        assert (err)
        else
            mismatch("pslverr", 32'd1, err);
        assert (got == 0)
        else
            mismatch("prdata", 32'd0, got);
        stop_run();
        apb_read(addr, got);
        assert (got == old)
        else
            mismatch("dmem after rejected write", old, got);

        apply_reset();
        build_alu_prog();
        run_and_compare();

        apply_reset();
        build_ldst_prog();
        run_and_compare();

        apply_reset();
        build_branch_prog();
        run_and_compare();

        // halt holds the cpu for as long as the button stays down
        apply_reset();
        build_halt_prog();
        load_program();
        run_model();
        @(posedge clk);
        halt_button <= 1'b1;
        start_run();
        hold = $urandom_range(60, 120);
        for (int c = 0; c < hold; c++)
        begin
            @(negedge clk);
            assert (!done)
            else
                mismatch("done", 32'd0, done);
        end
        @(posedge clk);
        halt_button <= 1'b0;
        wait_done(200);
        stop_run();
        check_dmem();

        // nothing may move in dmem while the cpu sits in done
        start_run();
        for (int c = 0; c < 200; c++)
        begin
            @(negedge clk);
            assert (done)
            else
                mismatch("done", 32'd1, done);
        end
        stop_run();
        for (int i = 0; i < `CPU_MEM_DEPTH; i++)
        begin
            apb_read(DMEM_SEL | 12'(i << 2), got);
            assert (got == snap[i])
            else
                mismatch($sformatf("dmem[%0d] after done", i), snap[i], got);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
